// File: Bender.yml
package:
  name: aes_cipher

sources:
  - source/aes_pkg.sv
  - source/aes_ctrl_pkg.sv
  - source/aes_sbox.sv
  - source/aes_round_fn.sv
  - source/aes_state_datapath.sv
  - source/aes_round_ctrl.sv
  - source/aes_result_port.sv
  - source/aes_cipher_top.sv
  - target: test
    files:
      - testbench/aes_tb_checker.sv
      - testbench/aes_tb_top.sv

// File: project.f
source/aes_pkg.sv
source/aes_ctrl_pkg.sv
source/aes_sbox.sv
source/aes_round_fn.sv
source/aes_state_datapath.sv
source/aes_round_ctrl.sv
source/aes_result_port.sv
source/aes_cipher_top.sv
testbench/aes_tb_checker.sv
testbench/aes_tb_top.sv

// File: source/aes_cipher_top.sv
// AES encipher core
// Iterative AES-128 and AES-256 encryption with external round keys,
// level ready on the input and a credit-based result output
`timescale 1ns/100ps
`default_nettype none

module aes_cipher_top (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      start,
  input  aes_ctrl_pkg::cipher_req_t req,
  output logic                      ready,
  output aes_pkg::round_t           round_idx,
  input  aes_pkg::block_t           round_key,
  input  logic                      result_credit,
  output logic                      result_valid,
  output aes_pkg::block_t           result
);

  aes_ctrl_pkg::update_e update;
  aes_ctrl_pkg::sword_t  sword;
  aes_pkg::word_t        sbox_in;
  aes_pkg::word_t        sbox_out;
  aes_pkg::block_t       state;
  logic                  push;
  logic                  slot_free;

  // ------------------------------------------------------------------
  // Round control
  // ------------------------------------------------------------------
  aes_round_ctrl u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .start     (start),
    .keylen    (req.keylen),
    .ready     (ready),
    .round_idx (round_idx),
    .update    (update),
    .sword     (sword),
    .slot_free (slot_free),
    .push      (push)
  );

  // State registers and round arithmetic
  aes_state_datapath u_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .update    (update),
    .sword     (sword),
    .in_block  (req.block),
    .round_key (round_key),
    .sbox_in   (sbox_in),
    .sbox_out  (sbox_out),
    .state     (state)
  );

  // Shared by all SubBytes cycles
  aes_sbox u_sbox (
    .in_word  (sbox_in),
    .out_word (sbox_out)
  );

  // Finished ciphertext waits here for a credit
  aes_result_port u_result (
    .clk           (clk),
    .reset_n       (reset_n),
    .push          (push),
    .push_data     (state),
    .slot_free     (slot_free),
    .result_credit (result_credit),
    .result_valid  (result_valid),
    .result        (result)
  );

endmodule

`default_nettype wire

// File: source/aes_ctrl_pkg.sv
// AES core control definitions
// FSM states, datapath update kinds, sub-word index,
// credit limit of the result port and the input request struct
`default_nettype none

package aes_ctrl_pkg;

  // Round FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_INIT,
    ST_SBOX,
    ST_MAIN,
    ST_FINAL,
    ST_HOLD
  } ctrl_state_e;

  // What the datapath does with its state words this cycle
  typedef enum logic [2:0] {
    UPD_NONE,
    UPD_INIT,
    UPD_SUB,
    UPD_MAIN,
    UPD_FINAL
  } update_e;

  // Which column goes through the S-box
  typedef logic [1:0] sword_t;

  // Credits held by the result port
  typedef logic [1:0] credit_t;
  localparam credit_t CREDIT_MAX = 2'd2;

  // One encipher request, 129 bits
  typedef struct packed {
    aes_pkg::block_t  block;
    aes_pkg::keylen_e keylen;
  } cipher_req_t;

endpackage

`default_nettype wire

// File: source/aes_pkg.sv
// AES algorithm definitions
// Widths of bytes, column words and blocks, round index type,
// key length select and the round count for each key length
`default_nettype none

package aes_pkg;

  // ------------------------------------------------------------------
  // Data widths
  // ------------------------------------------------------------------

  // One state byte
  typedef logic [7:0] byte_t;

  // One state column, four bytes, row 0 in the top byte
  typedef logic [31:0] word_t;

  // Full state, plaintext, ciphertext or round key
  typedef logic [127:0] block_t;

  // Round index, 0 up to 14
  typedef logic [3:0] round_t;

  // ------------------------------------------------------------------
  // Key length and round counts
  // ------------------------------------------------------------------
  typedef enum logic {
    KEY_128 = 1'b0,
    KEY_256 = 1'b1
  } keylen_e;

  localparam round_t AES128_ROUNDS = 4'd10;
  localparam round_t AES256_ROUNDS = 4'd14;

  // Columns in the state
  localparam int WORDS_PER_BLOCK = 4;

endpackage

`default_nettype wire

// File: source/aes_result_port.sv
// AES result port
// One-entry result buffer released under credit flow control,
// one credit consumed for each result_valid pulse
`timescale 1ns/100ps
`default_nettype none

module aes_result_port (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            push,
  input  aes_pkg::block_t push_data,
  output logic            slot_free,
  input  logic            result_credit,
  output logic            result_valid,
  output aes_pkg::block_t result
);

  logic                  full_q;
  aes_pkg::block_t       slot_q;
  aes_ctrl_pkg::credit_t credit_q;

  assign slot_free    = !full_q;
  // Fires as soon as a full slot meets a held credit
  assign result_valid = full_q && (credit_q != '0);
  assign result       = slot_q;

  // Result slot
  always_ff @(posedge clk)
  begin
    if (push)
      slot_q <= push_data;
  end

  // ------------------------------------------------------------------
  // Slot flag and credit counter
  // ------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      full_q   <= 1'b0;
      credit_q <= '0;
    end
    else
    begin
      if (push)
        full_q <= 1'b1;
      else if (result_valid)
        full_q <= 1'b0;

      // Credit in and result out in one cycle cancel out
      case ({result_credit, result_valid})
        2'b10:
          if (credit_q != aes_ctrl_pkg::CREDIT_MAX)
            credit_q <= credit_q + aes_ctrl_pkg::credit_t'(1);
        2'b01:   credit_q <= credit_q - aes_ctrl_pkg::credit_t'(1);
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Control only pushes into an empty slot
  a_push_into_free: assert property (
    @(posedge clk) disable iff (!reset_n) push |-> !full_q
  ) else $error("push while result slot full");

  // Consumer never returns more credits than the port can hold
  a_credit_limit: assert property (
    @(posedge clk) disable iff (!reset_n)
      (result_credit && !result_valid) |-> (credit_q != aes_ctrl_pkg::CREDIT_MAX)
  ) else $error("result_credit beyond limit of %0d", aes_ctrl_pkg::CREDIT_MAX);

endmodule

`default_nettype wire

// File: source/aes_round_ctrl.sv
// AES round control
// Round FSM with round and sub-word counters, key length capture,
// input ready and the push of the finished state to the result port
`timescale 1ns/100ps
`default_nettype none

module aes_round_ctrl (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  aes_pkg::keylen_e      keylen,
  output logic                  ready,
  output aes_pkg::round_t       round_idx,
  output aes_ctrl_pkg::update_e update,
  output aes_ctrl_pkg::sword_t  sword,
  input  logic                  slot_free,
  output logic                  push
);

  aes_ctrl_pkg::ctrl_state_e state_q;
  aes_ctrl_pkg::ctrl_state_e state_d;
  aes_pkg::keylen_e          keylen_q;
  aes_pkg::round_t           round_q;
  aes_pkg::round_t           num_rounds;
  aes_ctrl_pkg::sword_t      sword_q;
  logic                      accept;

  assign ready     = (state_q == aes_ctrl_pkg::ST_IDLE);
  assign accept    = start && ready;
  assign round_idx = round_q;
  assign sword     = sword_q;

  // Round count of the accepted request
  assign num_rounds = (keylen_q == aes_pkg::KEY_256) ? aes_pkg::AES256_ROUNDS
                                                     : aes_pkg::AES128_ROUNDS;

  // ------------------------------------------------------------------
  // Next state and datapath commands
  // ------------------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    update  = aes_ctrl_pkg::UPD_NONE;
    push    = 1'b0;
    case (state_q)
      aes_ctrl_pkg::ST_IDLE:
        if (accept)
          state_d = aes_ctrl_pkg::ST_INIT;
      aes_ctrl_pkg::ST_INIT:
      begin
        update  = aes_ctrl_pkg::UPD_INIT;
        state_d = aes_ctrl_pkg::ST_SBOX;
      end
      aes_ctrl_pkg::ST_SBOX:
      begin
        update = aes_ctrl_pkg::UPD_SUB;
        // Last column done, pick main or final step
        if (sword_q == 2'd3)
          state_d = (round_q == num_rounds) ? aes_ctrl_pkg::ST_FINAL
                                            : aes_ctrl_pkg::ST_MAIN;
      end
      aes_ctrl_pkg::ST_MAIN:
      begin
        update  = aes_ctrl_pkg::UPD_MAIN;
        state_d = aes_ctrl_pkg::ST_SBOX;
      end
      aes_ctrl_pkg::ST_FINAL:
      begin
        update  = aes_ctrl_pkg::UPD_FINAL;
        state_d = aes_ctrl_pkg::ST_HOLD;
      end
      aes_ctrl_pkg::ST_HOLD:
        // Wait here until the result slot is empty
        if (slot_free)
        begin
          push    = 1'b1;
          state_d = aes_ctrl_pkg::ST_IDLE;
        end
      default: state_d = aes_ctrl_pkg::ST_IDLE;
    endcase
  end

  // State, key length and counters
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_q  <= aes_ctrl_pkg::ST_IDLE;
      keylen_q <= aes_pkg::KEY_128;
      round_q  <= '0;
      sword_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        keylen_q <= keylen;
        round_q  <= '0;
        sword_q  <= '0;
      end
      else
      begin
        // Round index moves on after each key addition
        if (state_q == aes_ctrl_pkg::ST_INIT || state_q == aes_ctrl_pkg::ST_MAIN)
          round_q <= round_q + aes_pkg::round_t'(1);
        // Wraps to 0 after column 3
        if (state_q == aes_ctrl_pkg::ST_SBOX)
          sword_q <= sword_q + aes_ctrl_pkg::sword_t'(1);
      end
    end
  end

  // Key index stays inside the schedule of the accepted key length
  a_round_in_range: assert property (
    @(posedge clk) disable iff (!reset_n) round_idx <= num_rounds
  ) else $error("round_idx %0d beyond %0d rounds", round_idx, num_rounds);

endmodule

`default_nettype wire

// File: source/aes_round_fn.sv
// AES round function
// ShiftRows over the four columns, then MixColumns in GF(2^8)
// Gives the shifted state for the final round and the mixed
// state for the main rounds
`timescale 1ns/100ps
`default_nettype none

module aes_round_fn (
  input  aes_pkg::block_t state,
  output aes_pkg::block_t mixed,
  output aes_pkg::block_t shifted
);

  // Multiply by x, reduced by the AES polynomial
  function automatic aes_pkg::byte_t xtime(input aes_pkg::byte_t b);
    xtime = {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // Multiply by x+1
  function automatic aes_pkg::byte_t gm3(input aes_pkg::byte_t b);
    gm3 = xtime(b) ^ b;
  endfunction

  always_comb
  begin
    aes_pkg::byte_t col [4];

    shifted = '0;
    mixed   = '0;
    for (int c = 0; c < aes_pkg::WORDS_PER_BLOCK; c++)
    begin
      // Row r of column c comes from column c+r
      for (int r = 0; r < 4; r++)
      begin
        col[r] = state[127 - 32*((c + r) % aes_pkg::WORDS_PER_BLOCK) - 8*r -: 8];
      end
      shifted[127 - 32*c -: 32] = {col[0], col[1], col[2], col[3]};

      // Fixed MixColumns matrix, rows of 2 3 1 1 rotated
      mixed[127 - 32*c -: 32] = {
        xtime(col[0]) ^ gm3(col[1]) ^ col[2] ^ col[3],
        col[0] ^ xtime(col[1]) ^ gm3(col[2]) ^ col[3],
        col[0] ^ col[1] ^ xtime(col[2]) ^ gm3(col[3]),
        gm3(col[0]) ^ col[1] ^ col[2] ^ xtime(col[3])
      };
    end
  end

endmodule

`default_nettype wire

// File: source/aes_sbox.sv
// AES forward S-box
// Substitutes all four bytes of one column word through the
// 256-entry SubBytes table, purely combinational
`timescale 1ns/100ps
`default_nettype none

module aes_sbox (
  input  aes_pkg::word_t in_word,
  output aes_pkg::word_t out_word
);

  // ------------------------------------------------------------------
  // Forward substitution table, index 8'h00 first
  // ------------------------------------------------------------------
  localparam aes_pkg::byte_t SBOX [0:255] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // ------------------------------------------------------------------
  // One table lookup per byte lane
  // ------------------------------------------------------------------
  for (genvar i = 0; i < $bits(aes_pkg::word_t) / $bits(aes_pkg::byte_t); i++)
  begin : g_lane
    // Lane i covers bits 8*i+7 down to 8*i
    assign out_word[8*i +: 8] = SBOX[in_word[8*i +: 8]];
  end

endmodule

`default_nettype wire

// File: source/aes_state_datapath.sv
// AES state datapath
// Four column-word registers updated by the initial key addition,
// one S-box word per cycle, and the main and final round steps
`timescale 1ns/100ps
`default_nettype none

module aes_state_datapath (
  input  logic                  clk,
  input  logic                  reset_n,
  input  aes_ctrl_pkg::update_e update,
  input  aes_ctrl_pkg::sword_t  sword,
  input  aes_pkg::block_t       in_block,
  input  aes_pkg::block_t       round_key,
  output aes_pkg::word_t        sbox_in,
  input  aes_pkg::word_t        sbox_out,
  output aes_pkg::block_t       state
);

  aes_pkg::word_t  state_w [aes_pkg::WORDS_PER_BLOCK];
  aes_pkg::block_t in_q;
  aes_pkg::block_t next_blk;
  aes_pkg::block_t mixed;
  aes_pkg::block_t shifted;

  // Column 0 sits in the top word
  assign state   = {state_w[0], state_w[1], state_w[2], state_w[3]};
  assign sbox_in = state_w[sword];

  aes_round_fn u_round_fn (
    .state   (state),
    .mixed   (mixed),
    .shifted (shifted)
  );

  // Input block capture, follows the request while the engine idles
  always_ff @(posedge clk)
  begin
    if (update == aes_ctrl_pkg::UPD_NONE)
    begin
      in_q <= in_block;
    end
  end

  // ------------------------------------------------------------------
  // Next state select
  // ------------------------------------------------------------------
  always_comb
  begin
    next_blk = state;
    case (update)
      // Initial AddRoundKey with key 0
      aes_ctrl_pkg::UPD_INIT:  next_blk = in_q ^ round_key;
      // SubBytes on the selected column only
      aes_ctrl_pkg::UPD_SUB:
        next_blk[32 * (aes_pkg::WORDS_PER_BLOCK - 1 - int'(sword)) +: 32] = sbox_out;
      aes_ctrl_pkg::UPD_MAIN:  next_blk = mixed ^ round_key;
      // Last round skips MixColumns
      aes_ctrl_pkg::UPD_FINAL: next_blk = shifted ^ round_key;
      default:                 next_blk = state;
    endcase
  end

  // State word registers
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < aes_pkg::WORDS_PER_BLOCK; i++)
    begin
      if (!reset_n)
      begin
        state_w[i] <= '0;
      end
      else
      begin
        state_w[i] <= next_blk[127 - 32*i -: 32];
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/aes_tb_checker.sv
// AES core result checker
// Reference AES model with an S-box built from GF(2^8) inversion,
// expected result queue, credit tracking, ready rules and latency
`timescale 1ns/100ps
`default_nettype none

module aes_tb_checker (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      start,
  input  aes_ctrl_pkg::cipher_req_t req,
  input  logic                      ready,
  input  aes_pkg::block_t [14:0]    keys,
  input  logic                      result_credit,
  input  logic                      result_valid,
  input  aes_pkg::block_t           result,
  output int                        value_errors,
  output int                        protocol_errors,
  output int                        timing_errors,
  output int                        results_seen,
  output int                        fixed_checks
);

  aes_pkg::byte_t  sbox_tab [256];
  aes_pkg::block_t exp_q [$];
  int              acc_cycle_q [$];
  // Expected latency, 0 when the latency is not fixed
  int              lat_q [$];
  int              cycle;
  int              credits;
  int              credits_given;
  logic            first_cycle;
  logic            accepted_last;

  // ------------------------------------------------------------------
  // GF(2^8) arithmetic and reference S-box
  // ------------------------------------------------------------------
  function automatic aes_pkg::byte_t gf_mul(input aes_pkg::byte_t a, input aes_pkg::byte_t b);
    aes_pkg::byte_t p;
    aes_pkg::byte_t x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        p = p ^ x;
      x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
    end
    return p;
  endfunction

  // Inverse as a^254, zero maps to zero
  function automatic aes_pkg::byte_t gf_inv(input aes_pkg::byte_t a);
    aes_pkg::byte_t r;
    r = 8'h01;
    for (int i = 0; i < 254; i++)
      r = gf_mul(r, a);
    return r;
  endfunction

  function automatic aes_pkg::byte_t rotl8(input aes_pkg::byte_t b, input int n);
    return (b << n) | (b >> (8 - n));
  endfunction

  // Affine map applied after inversion
  function automatic aes_pkg::byte_t sbox_entry(input aes_pkg::byte_t x);
    aes_pkg::byte_t b;
    b = gf_inv(x);
    return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
  endfunction

  // ------------------------------------------------------------------
  // Reference cipher, bytes in column-major order
  // ------------------------------------------------------------------
  function automatic aes_pkg::block_t aes_encrypt(input aes_pkg::block_t pt, input int rounds,
                                                  input aes_pkg::block_t [14:0] rkeys);
    aes_pkg::byte_t  s [16];
    aes_pkg::byte_t  t [16];
    aes_pkg::byte_t  a0;
    aes_pkg::byte_t  a1;
    aes_pkg::byte_t  a2;
    aes_pkg::byte_t  a3;
    aes_pkg::block_t out;
    for (int i = 0; i < 16; i++)
      s[i] = pt[127 - 8*i -: 8] ^ rkeys[0][127 - 8*i -: 8];
    for (int rnd = 1; rnd <= rounds; rnd++)
    begin
      // SubBytes then ShiftRows, row r rotated left by r
      for (int c = 0; c < 4; c++)
        for (int row = 0; row < 4; row++)
          t[4*c + row] = sbox_tab[s[4*((c + row) % 4) + row]];
      for (int c = 0; c < 4; c++)
      begin
        a0 = t[4*c];
        a1 = t[4*c + 1];
        a2 = t[4*c + 2];
        a3 = t[4*c + 3];
        if (rnd == rounds)
        begin
          // No MixColumns in the last round
          s[4*c]     = a0;
          s[4*c + 1] = a1;
          s[4*c + 2] = a2;
          s[4*c + 3] = a3;
        end
        else
        begin
          s[4*c]     = gf_mul(8'h02, a0) ^ gf_mul(8'h03, a1) ^ a2 ^ a3;
          s[4*c + 1] = a0 ^ gf_mul(8'h02, a1) ^ gf_mul(8'h03, a2) ^ a3;
          s[4*c + 2] = a0 ^ a1 ^ gf_mul(8'h02, a2) ^ gf_mul(8'h03, a3);
          s[4*c + 3] = gf_mul(8'h03, a0) ^ a1 ^ a2 ^ gf_mul(8'h02, a3);
        end
      end
      for (int i = 0; i < 16; i++)
        s[i] = s[i] ^ rkeys[rnd][127 - 8*i -: 8];
    end
    for (int i = 0; i < 16; i++)
      out[127 - 8*i -: 8] = s[i];
    return out;
  endfunction

  initial
  begin
    for (int i = 0; i < 256; i++)
      sbox_tab[i] = sbox_entry(aes_pkg::byte_t'(i));
    value_errors    = 0;
    protocol_errors = 0;
    timing_errors   = 0;
    results_seen    = 0;
    fixed_checks    = 0;
    cycle           = 0;
    credits         = 0;
    credits_given   = 0;
    first_cycle     = 1'b0;
    accepted_last   = 1'b0;
  end

  // ------------------------------------------------------------------
  // Monitor, sampled at the falling edge where all signals are stable
  // ------------------------------------------------------------------
  always @(negedge clk)
  begin : monitor
    int              held;
    int              outstanding;
    int              rounds;
    int              acc;
    int              lat;
    aes_pkg::block_t expected;
    if (!reset_n)
    begin
      exp_q.delete();
      acc_cycle_q.delete();
      lat_q.delete();
      credits       = 0;
      first_cycle   = 1'b1;
      accepted_last = 1'b0;
    end
    else
    begin
      cycle++;
      held        = credits;
      outstanding = exp_q.size();
      if (first_cycle && ready !== 1'b1)
      begin
        $display("ERROR ready: expected %h, got %h after reset", 1'b1, ready);
        protocol_errors++;
      end
      first_cycle = 1'b0;

      // Ready rules
      if (accepted_last && ready)
      begin
        $display("ready stayed high in the cycle after an acceptance");
        protocol_errors++;
      end
      if (ready && outstanding >= 2)
      begin
        $display("ready high while the engine and the result slot are both occupied");
        protocol_errors++;
      end
      accepted_last = 1'b0;

      // Result side
      if (result_valid)
      begin
        results_seen++;
        if (held == 0)
        begin
          $display("result_valid at cycle %0d without a held credit", cycle);
          protocol_errors++;
        end
        if (results_seen > credits_given)
        begin
          $display("More results than credits returned at cycle %0d", cycle);
          protocol_errors++;
        end
        if (outstanding == 0)
        begin
          $display("result_valid at cycle %0d with no request outstanding", cycle);
          protocol_errors++;
        end
        else
        begin
          expected = exp_q.pop_front();
          acc      = acc_cycle_q.pop_front();
          lat      = lat_q.pop_front();
          if (result !== expected)
          begin
            $display("ERROR result: expected %h, got %h", expected, result);
            value_errors++;
          end
          if (lat != 0)
          begin
            fixed_checks++;
            if (cycle - acc != lat)
            begin
              $display("Result came %0d cycles after acceptance instead of %0d",
                       cycle - acc, lat);
              timing_errors++;
            end
          end
        end
      end

      // Credits held by the core
      if (result_credit)
        credits_given++;
      credits = held + int'(result_credit) - int'(result_valid);

      // Acceptance happens at the next rising edge
      if (start && ready)
      begin
        rounds = (req.keylen == aes_pkg::KEY_256) ? int'(aes_pkg::AES256_ROUNDS)
                                                  : int'(aes_pkg::AES128_ROUNDS);
        exp_q.push_back(aes_encrypt(req.block, rounds, keys));
        acc_cycle_q.push_back(cycle);
        // INIT, 5 cycles per round, HOLD, then output
        lat_q.push_back((outstanding == 0 && held > 0) ? 5 * rounds + 3 : 0);
        accepted_last = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/aes_tb_top.sv
// AES core testbench
// Clock source, reset, seeded random requests with round keys,
// credit back-pressure, idle start pulses and a watchdog
`timescale 1ns/100ps
`default_nettype none

module aes_tb_clock (
  output logic clk
);

  // 10 ns period
  initial clk = 1'b0;
  always #5 clk = ~clk;

endmodule

module aes_tb_top;

  localparam int  NUM_REQS        = 40;
  localparam int  RESET_CYCLES    = 8;
  localparam int  SEED            = 64266;
  localparam int  WATCHDOG_CYCLES = NUM_REQS * 90 + 1000;
  localparam int  PHASE_CYCLES    = 32;

  logic                      clk;
  logic                      reset_n;
  logic                      start;
  aes_ctrl_pkg::cipher_req_t req;
  logic                      ready;
  aes_pkg::round_t           round_idx;
  aes_pkg::block_t           round_key;
  logic                      result_credit;
  logic                      result_valid;
  aes_pkg::block_t           result;
  aes_ctrl_pkg::cipher_req_t next_req;
  aes_pkg::block_t [14:0]    next_keys;
  aes_pkg::block_t [14:0]    cur_keys;
  int                        value_errors;
  int                        protocol_errors;
  int                        timing_errors;
  int                        results_seen;
  int                        fixed_checks;

  aes_tb_clock u_clock (
    .clk (clk)
  );

  aes_cipher_top uut (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .req           (req),
    .ready         (ready),
    .round_idx     (round_idx),
    .round_key     (round_key),
    .result_credit (result_credit),
    .result_valid  (result_valid),
    .result        (result)
  );

  aes_tb_checker u_checker (
    .clk             (clk),
    .reset_n         (reset_n),
    .start           (start),
    .req             (req),
    .ready           (ready),
    .keys            (next_keys),
    .result_credit   (result_credit),
    .result_valid    (result_valid),
    .result          (result),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .timing_errors   (timing_errors),
    .results_seen    (results_seen),
    .fixed_checks    (fixed_checks)
  );

  // External key store, indexed by the core
  assign round_key = cur_keys[round_idx];

  // Random block, key length and 15 round keys
  task automatic make_request();
    next_req.block  = {$urandom, $urandom, $urandom, $urandom};
    next_req.keylen = aes_pkg::keylen_e'($urandom_range(0, 1));
    for (int k = 0; k < 15; k++)
      next_keys[k] = {$urandom, $urandom, $urandom, $urandom};
  endtask

  // ------------------------------------------------------------------
  // Stimulus, driven 1 ns after each rising edge
  // ------------------------------------------------------------------
  initial
  begin : stimulus
    int   seed;
    int   sent;
    int   gap;
    int   held;
    int   mode;
    int   phase_left;
    logic accept_pending;
    logic credit_prev;
    logic valid_prev;

    seed = SEED;
    void'($urandom(seed));
    reset_n        = 1'b0;
    start          = 1'b0;
    req            = '0;
    result_credit  = 1'b0;
    next_req       = '0;
    next_keys      = '0;
    cur_keys       = '0;
    sent           = 0;
    gap            = 0;
    held           = 0;
    mode           = 2;
    phase_left     = 0;
    accept_pending = 1'b0;
    credit_prev    = 1'b0;
    valid_prev     = 1'b0;
    make_request();

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;

    while (results_seen < NUM_REQS)
    begin
      @(posedge clk);
      #1;
      // Credits now held by the core
      held       = held + int'(credit_prev) - int'(valid_prev);
      valid_prev = result_valid;
      // Stall, sparse or dense credit phases
      if (phase_left == 0)
      begin
        mode       = $urandom_range(0, 3);
        phase_left = PHASE_CYCLES;
      end
      phase_left--;
      if (held < int'(aes_ctrl_pkg::CREDIT_MAX) || result_valid)
      begin
        case (mode)
          0:       result_credit = 1'b0;
          1:       result_credit = ($urandom_range(0, 7) == 0);
          default: result_credit = ($urandom_range(0, 1) == 0);
        endcase
      end
      else
        result_credit = 1'b0;
      credit_prev = result_credit;

      // Keys switch right after the accepting edge
      if (accept_pending)
      begin
        cur_keys       = next_keys;
        accept_pending = 1'b0;
        sent++;
        if (sent < NUM_REQS)
          make_request();
        // Long gaps let credits pile up for the fixed latency case
        gap = ($urandom_range(0, 3) == 0) ? $urandom_range(10, 30) : $urandom_range(0, 2);
      end

      if (!ready)
      begin
        // Busy core ignores these
        start      = ($urandom_range(0, 3) == 0);
        req.block  = {$urandom, $urandom, $urandom, $urandom};
        req.keylen = aes_pkg::keylen_e'($urandom_range(0, 1));
      end
      else if (sent < NUM_REQS && gap == 0)
      begin
        start          = 1'b1;
        req            = next_req;
        accept_pending = 1'b1;
      end
      else
      begin
        start = 1'b0;
        if (gap > 0)
          gap--;
      end
    end

    start         = 1'b0;
    result_credit = 1'b0;
    repeat (4) @(posedge clk);
    if (fixed_checks == 0)
      $display("No result was checked against the fixed latency");
    $display("Results %0d, fixed latency checks %0d, errors value %0d protocol %0d timing %0d",
             results_seen, fixed_checks, value_errors, protocol_errors, timing_errors);
    if (value_errors + protocol_errors + timing_errors == 0 && fixed_checks > 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Watchdog sized from the request count
  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d results received",
             WATCHDOG_CYCLES, results_seen, NUM_REQS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
